// File: hdl/dsi_pkg.sv
package dsi_pkg;

    // lanes controller takes one 32-bit word per transfer
    localparam int DSI_WORD_BYTES = 4;

    localparam logic [7:0] DT_VSS    = 8'h01; // vertical sync start, short packet
    localparam logic [7:0] DT_HSS    = 8'h21; // horizontal sync start, short packet
    localparam logic [7:0] DT_BLANK  = 8'h19; // blanking packet, long
    localparam logic [7:0] DT_RGB888 = 8'h3E; // packed 24-bit pixel stream, long

    localparam logic [31:0] BLANK_PATTERN = 32'h5555_5555; // payload of every blanking word

    typedef enum logic [1:0]
    {
        PKT_VSS,
        PKT_HSS,
        PKT_BLANK,
        PKT_PIXEL
    } pkt_kind_t;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_VSS,
        ST_HSS_V,  // sync of a vsync, back porch or front porch line
        ST_BL_V,   // full-width blanking of such a line
        ST_HSS_A,  // sync of an active line
        ST_HBP,
        ST_RGB,
        ST_HFP
    } frame_state_t;

    typedef enum logic [1:0]
    {
        REG_VSYNC,
        REG_VBP,
        REG_ACTIVE,
        REG_VFP
    } region_t;

endpackage

// File: hdl/dsi_ecc_calc.sv
`timescale 1ns/1ps

module dsi_ecc_calc
(
    input  logic [23:0] header,
    output logic [7:0]  ecc
);

    // each mask selects the header bits that feed one parity bit
    localparam logic [23:0] P0_MASK = 24'hF1_2CB7;
    localparam logic [23:0] P1_MASK = 24'hF2_555B;
    localparam logic [23:0] P2_MASK = 24'h74_9A6D;
    localparam logic [23:0] P3_MASK = 24'hB8_E38E;
    localparam logic [23:0] P4_MASK = 24'hDF_03F0;
    localparam logic [23:0] P5_MASK = 24'hEF_FC00;

    assign ecc[0] = ^(header & P0_MASK);
    assign ecc[1] = ^(header & P1_MASK);
    assign ecc[2] = ^(header & P2_MASK);
    assign ecc[3] = ^(header & P3_MASK);
    assign ecc[4] = ^(header & P4_MASK);
    assign ecc[5] = ^(header & P5_MASK);

    assign ecc[7:6] = 2'b00; // reserved, always zero

endmodule

// File: hdl/dsi_crc16.sv
`timescale 1ns/1ps

module dsi_crc16
(
    input  logic        clk_sys,
    input  logic        reset_stop_read_data_hs,
    input  logic        clear,
    input  logic        update,
    input  logic [31:0] data,
    output logic [15:0] crc
);

    localparam logic [15:0] CRC_POLY = 16'h8408; // reflected 0x1021
    localparam logic [15:0] CRC_INIT = 16'hFFFF;

    logic [15:0] crc_q;
    logic [15:0] crc_next;

    // bytes go in order 0 to 3 and each byte lsb first, so the word is simply walked from bit 0
    always_comb
    begin
        crc_next = crc_q;
        for (int i = 0; i < 32; i++)
        begin
            if (crc_next[0] ^ data[i])
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs || clear)
            crc_q <= CRC_INIT;
        else if (update)
            crc_q <= crc_next;
    end

    assign crc = crc_q; // holds the crc of all payload words taken so far

endmodule

// File: hdl/dsi_line_timer.sv
`timescale 1ns/1ps

module dsi_line_timer
    import dsi_pkg::*;
#(
    parameter int VSA_LINES      = 1,
    parameter int VBP_LINES      = 1,
    parameter int V_ACTIVE_LINES = 3,
    parameter int VFP_LINES      = 1
)(
    input  logic    clk_sys,
    input  logic    reset_stop_read_data_hs,
    input  logic    frame_start,
    input  logic    line_done,
    output region_t region,
    output logic    last_line
);

    localparam int MAX_AB    = (VSA_LINES > VBP_LINES) ? VSA_LINES : VBP_LINES;
    localparam int MAX_CD    = (V_ACTIVE_LINES > VFP_LINES) ? V_ACTIVE_LINES : VFP_LINES;
    localparam int MAX_LINES = (MAX_AB > MAX_CD) ? MAX_AB : MAX_CD;
    localparam int CNT_W     = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1;

    logic [CNT_W-1:0] lines_left; // lines after the current one in this region
    region_t          region_next;

    function automatic logic [CNT_W-1:0] region_lines(input region_t r);
        case (r)
            REG_VSYNC:  return CNT_W'(VSA_LINES - 1);
            REG_VBP:    return CNT_W'(VBP_LINES - 1);
            REG_ACTIVE: return CNT_W'(V_ACTIVE_LINES - 1);
            default:    return CNT_W'(VFP_LINES - 1);
        endcase
    endfunction

    always_comb
    begin
        case (region)
            REG_VSYNC:  region_next = REG_VBP;
            REG_VBP:    region_next = REG_ACTIVE;
            REG_ACTIVE: region_next = REG_VFP;
            default:    region_next = REG_VSYNC;
        endcase
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs || frame_start)
        begin
            region     <= REG_VSYNC;
            lines_left <= region_lines(REG_VSYNC);
        end
        else if (line_done)
        begin
            if (lines_left == '0)
            begin
                region     <= region_next;
                lines_left <= region_lines(region_next);
            end
            else
                lines_left <= lines_left - 1'b1;
        end
    end

    assign last_line = (lines_left == '0);

endmodule

// File: hdl/dsi_frame_fsm.sv
`timescale 1ns/1ps

module dsi_frame_fsm
    import dsi_pkg::*;
#(
    parameter int H_BACK_WORDS   = 2,
    parameter int H_ACTIVE_WORDS = 4,
    parameter int H_FRONT_WORDS  = 2,
    parameter int WC_WIDTH       = 16
)(
    input  logic                clk_sys,
    input  logic                reset_stop_read_data_hs,
    input  logic                streaming_enable,
    input  region_t             region,
    input  logic                last_line,
    input  logic                pkt_done,
    output logic                pkt_start,
    output pkt_kind_t           pkt_kind,
    output logic [WC_WIDTH-1:0] pkt_words,
    output logic                line_done,
    output logic                frame_start
);

    localparam int LINE_WORDS = H_BACK_WORDS + H_ACTIVE_WORDS + H_FRONT_WORDS;

    frame_state_t state_q;
    frame_state_t state_d;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (streaming_enable) state_d = ST_VSS;
            ST_VSS:   if (pkt_done) state_d = ST_HSS_V;
            ST_HSS_V: if (pkt_done) state_d = ST_BL_V;
            ST_BL_V:
            begin
                if (pkt_done)
                begin
                    if (region == REG_VFP && last_line)
                        state_d = streaming_enable ? ST_VSS : ST_IDLE; // frame ends here
                    else if (region == REG_VBP && last_line)
                        state_d = ST_HSS_A;
                    else
                        state_d = ST_HSS_V;
                end
            end
            ST_HSS_A: if (pkt_done) state_d = ST_HBP;
            ST_HBP:   if (pkt_done) state_d = ST_RGB;
            ST_RGB:   if (pkt_done) state_d = ST_HFP;
            ST_HFP:
            begin
                if (pkt_done)
                    state_d = last_line ? ST_HSS_V : ST_HSS_A; // last active line leads into vfp
            end
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs)
        begin
            state_q   <= ST_IDLE;
            pkt_start <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            pkt_start <= (state_d != state_q) && (state_d != ST_IDLE); // every entry sends one packet
        end
    end

    // the packet command follows the registered state, so it is valid with pkt_start
    always_comb
    begin
        pkt_kind  = PKT_VSS;
        pkt_words = '0;
        case (state_q)
            ST_HSS_V, ST_HSS_A: pkt_kind = PKT_HSS;
            ST_BL_V:
            begin
                pkt_kind  = PKT_BLANK;
                pkt_words = WC_WIDTH'(LINE_WORDS);
            end
            ST_HBP:
            begin
                pkt_kind  = PKT_BLANK;
                pkt_words = WC_WIDTH'(H_BACK_WORDS);
            end
            ST_RGB:
            begin
                pkt_kind  = PKT_PIXEL;
                pkt_words = WC_WIDTH'(H_ACTIVE_WORDS);
            end
            ST_HFP:
            begin
                pkt_kind  = PKT_BLANK;
                pkt_words = WC_WIDTH'(H_FRONT_WORDS);
            end
            default: ;
        endcase
    end

    assign line_done   = pkt_done && (state_q == ST_BL_V || state_q == ST_HFP); // last packet of a line
    assign frame_start = (state_d == ST_VSS) && (state_q != ST_VSS);

endmodule

// File: hdl/dsi_packet_serializer.sv
`timescale 1ns/1ps

module dsi_packet_serializer
    import dsi_pkg::*;
#(
    parameter int MAX_WORDS = 8,
    parameter int WC_WIDTH  = 16
)(
    input  logic                clk_sys,
    input  logic                reset_stop_read_data_hs,
    input  logic                pkt_start,
    input  pkt_kind_t           pkt_kind,
    input  logic [WC_WIDTH-1:0] pkt_words,
    output logic                pkt_done,
    input  logic [31:0]         pix_fifo_data,
    input  logic                pix_fifo_empty,
    output logic                pix_fifo_read,
    input  logic                data_rqst,
    output logic [31:0]         write_data,
    output logic [3:0]          write_strb,
    output logic                write_rqst,
    output logic                last_word
);

    localparam int CNT_W = $clog2(MAX_WORDS + 1);

    // what the output register is loaded with next
    typedef enum logic [1:0] {PH_IDLE, PH_PAY, PH_CRC, PH_LAST} phase_t;

    phase_t           phase_q;
    pkt_kind_t        kind_q;
    logic [CNT_W-1:0] words_left;
    logic             long_pkt;
    logic [7:0]       data_id;
    logic [15:0]      wc_bytes;
    logic [23:0]      header;
    logic [7:0]       ecc;
    logic             pixel_q;
    logic             load_pay;
    logic [31:0]      pay_word;
    logic [15:0]      crc;

    always_comb
    begin
        case (pkt_kind)
            PKT_VSS:   data_id = DT_VSS;
            PKT_HSS:   data_id = DT_HSS;
            PKT_BLANK: data_id = DT_BLANK;
            default:   data_id = DT_RGB888;
        endcase
    end

    assign long_pkt = (pkt_kind == PKT_BLANK) || (pkt_kind == PKT_PIXEL);
    assign wc_bytes = long_pkt ? 16'(pkt_words * DSI_WORD_BYTES) : 16'h0000; // count is in bytes
    assign header   = {wc_bytes, data_id};

    dsi_ecc_calc u_ecc
    (
        .header (header),
        .ecc    (ecc)
    );

    assign pixel_q       = (kind_q == PKT_PIXEL);
    assign load_pay      = data_rqst && (phase_q == PH_PAY) && (!pixel_q || !pix_fifo_empty);
    assign pix_fifo_read = load_pay && pixel_q;
    assign pay_word      = pixel_q ? pix_fifo_data : BLANK_PATTERN;
    assign pkt_done      = write_rqst && data_rqst && last_word;

    dsi_crc16 u_crc
    (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .clear                   (pkt_start),
        .update                  (load_pay),
        .data                    (pay_word),
        .crc                     (crc)
    );

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs)
        begin
            phase_q    <= PH_IDLE;
            write_rqst <= 1'b0;
            write_strb <= 4'b1111;
            last_word  <= 1'b0;
        end
        else if (pkt_start)
        begin
            write_rqst <= 1'b1;
            write_strb <= 4'b1111;
            last_word  <= !long_pkt; // a short packet is its header alone
            if (!long_pkt)
                phase_q <= PH_LAST;
            else if (pkt_words == '0)
                phase_q <= PH_CRC;
            else
                phase_q <= PH_PAY;
        end
        else if (data_rqst)
        begin
            case (phase_q)
                PH_PAY:
                begin
                    write_rqst <= load_pay; // drops while the pixel fifo runs dry
                    if (load_pay && words_left == CNT_W'(1))
                        phase_q <= PH_CRC;
                end
                PH_CRC:
                begin
                    write_rqst <= 1'b1;
                    write_strb <= 4'b0011;
                    last_word  <= 1'b1;
                    phase_q    <= PH_LAST;
                end
                PH_LAST:
                begin
                    write_rqst <= 1'b0;
                    write_strb <= 4'b1111;
                    last_word  <= 1'b0;
                    phase_q    <= PH_IDLE;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (pkt_start)
        begin
            write_data <= {ecc, header};
            kind_q     <= pkt_kind;
            words_left <= CNT_W'(pkt_words);
        end
        else if (load_pay)
        begin
            write_data <= pay_word;
            words_left <= words_left - 1'b1;
        end
        else if (data_rqst && phase_q == PH_CRC)
            write_data <= {16'h0000, crc}; // low byte of the crc goes out first
    end

endmodule

// File: hdl/dsi_video_assembler.sv
`timescale 1ns/1ps

module dsi_video_assembler
    import dsi_pkg::*;
#(
    parameter int H_BACK_WORDS   = 2,
    parameter int H_ACTIVE_WORDS = 4,
    parameter int H_FRONT_WORDS  = 2,
    parameter int VSA_LINES      = 1,
    parameter int VBP_LINES      = 1,
    parameter int V_ACTIVE_LINES = 3,
    parameter int VFP_LINES      = 1,
    parameter int WC_WIDTH       = 16
)(
    input  logic        clk_sys,
    input  logic        reset_stop_read_data_hs,
    input  logic        streaming_enable,
    input  logic [31:0] pix_fifo_data,
    input  logic        pix_fifo_empty,
    output logic        pix_fifo_read,
    input  logic        data_rqst,
    output logic [31:0] write_data,
    output logic [3:0]  write_strb,
    output logic        write_rqst,
    output logic        last_word
);

    // a blanking line is the longest packet the serializer has to count
    localparam int MAX_WORDS = H_BACK_WORDS + H_ACTIVE_WORDS + H_FRONT_WORDS;

    logic                pkt_start;
    pkt_kind_t           pkt_kind;
    logic [WC_WIDTH-1:0] pkt_words;
    logic                pkt_done;
    logic                line_done;
    logic                frame_start;
    region_t             region;
    logic                last_line;

    dsi_frame_fsm #(
        .H_BACK_WORDS   (H_BACK_WORDS),
        .H_ACTIVE_WORDS (H_ACTIVE_WORDS),
        .H_FRONT_WORDS  (H_FRONT_WORDS),
        .WC_WIDTH       (WC_WIDTH)
    ) u_fsm (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .streaming_enable        (streaming_enable),
        .region                  (region),
        .last_line               (last_line),
        .pkt_done                (pkt_done),
        .pkt_start               (pkt_start),
        .pkt_kind                (pkt_kind),
        .pkt_words               (pkt_words),
        .line_done               (line_done),
        .frame_start             (frame_start)
    );

    dsi_line_timer #(
        .VSA_LINES      (VSA_LINES),
        .VBP_LINES      (VBP_LINES),
        .V_ACTIVE_LINES (V_ACTIVE_LINES),
        .VFP_LINES      (VFP_LINES)
    ) u_timer (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .frame_start             (frame_start),
        .line_done               (line_done),
        .region                  (region),
        .last_line               (last_line)
    );

    dsi_packet_serializer #(
        .MAX_WORDS (MAX_WORDS),
        .WC_WIDTH  (WC_WIDTH)
    ) u_ser (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .pkt_start               (pkt_start),
        .pkt_kind                (pkt_kind),
        .pkt_words               (pkt_words),
        .pkt_done                (pkt_done),
        .pix_fifo_data           (pix_fifo_data),
        .pix_fifo_empty          (pix_fifo_empty),
        .pix_fifo_read           (pix_fifo_read),
        .data_rqst               (data_rqst),
        .write_data              (write_data),
        .write_strb              (write_strb),
        .write_rqst              (write_rqst),
        .last_word               (last_word)
    );

endmodule

// File: test/dsi_assembler_checker.sv
`timescale 1ns/1ps

module dsi_assembler_checker
(
    input logic        clk_sys,
    input logic        reset_stop_read_data_hs,
    input logic        data_rqst,
    input logic        write_rqst,
    input logic [31:0] write_data,
    input logic [3:0]  write_strb,
    input logic        last_word,
    input logic        pix_fifo_read,
    input logic        pix_fifo_empty
);

    int fail_count = 0; // read by the testbench to end the run on a failed assertion

    // a word that is offered but not taken stays exactly as it was
    property outputs_hold;
        @(posedge clk_sys) disable iff (reset_stop_read_data_hs)
            (write_rqst && !data_rqst) |=> (write_rqst && $stable(write_data)
                && $stable(write_strb) && $stable(last_word));
    endproperty

    a_hold: assert property (outputs_hold)
        else begin $error("word changed while data_rqst was low"); fail_count++; end

    a_no_read_empty: assert property (@(posedge clk_sys) disable iff (reset_stop_read_data_hs)
        pix_fifo_read |-> !pix_fifo_empty)
        else begin $error("pixel fifo read while empty"); fail_count++; end

    a_last_valid: assert property (@(posedge clk_sys) disable iff (reset_stop_read_data_hs)
        last_word |-> write_rqst)
        else begin $error("last_word without write_rqst"); fail_count++; end

    a_strb_legal: assert property (@(posedge clk_sys) disable iff (reset_stop_read_data_hs)
        write_rqst |-> (write_strb == 4'b1111 || write_strb == 4'b0011))
        else begin $error("illegal write_strb value"); fail_count++; end

endmodule

// File: test/tb_dsi_video_assembler.sv
`timescale 1ns/1ps

module tb_dsi_video_assembler;

    localparam int H_BACK_WORDS   = 2;
    localparam int H_ACTIVE_WORDS = 4;
    localparam int H_FRONT_WORDS  = 2;
    localparam int VSA_LINES      = 1;
    localparam int VBP_LINES      = 1;
    localparam int V_ACTIVE_LINES = 3;
    localparam int VFP_LINES      = 1;
    localparam int LINE_WORDS     = H_BACK_WORDS + H_ACTIVE_WORDS + H_FRONT_WORDS;
    // vss, then blank lines of hss plus one long packet, then active lines of hss plus three
    localparam int FRAME_WORDS    = 1 + (VSA_LINES + VBP_LINES + VFP_LINES) * (LINE_WORDS + 3)
                                      + V_ACTIVE_LINES * (LINE_WORDS + 7);
    localparam int WORST_STALL    = 4;
    localparam int WATCH_LIMIT    = 4 * 3 * FRAME_WORDS * WORST_STALL;
    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 20;
    localparam logic [31:0] RAND_SEED = 32'h5c6b_7d32;
    localparam logic [31:0] PIX_BASE  = 32'h3E00_0100; // first word the pixel fifo hands out

    logic        clk_sys;
    logic        reset_stop_read_data_hs;
    logic        streaming_enable;
    logic [31:0] pix_fifo_data;
    logic        pix_fifo_empty;
    logic        pix_fifo_read;
    logic        data_rqst;
    logic [31:0] write_data;
    logic [3:0]  write_strb;
    logic        write_rqst;
    logic        last_word;

    logic [31:0] exp_data[$];
    logic [3:0]  exp_strb[$];
    logic        exp_last[$];
    logic [31:0] ref_pix;              // pixel index used while building the reference
    logic [31:0] pix_next;             // index of the word the fifo model shows
    logic        pix_take = 1'b0;      // fifo word is taken at the coming edge
    logic        stall_en;
    logic        underrun_en;
    logic        watch_on;
    int          watch_cycles;

    dsi_video_assembler #(
        .H_BACK_WORDS   (H_BACK_WORDS),
        .H_ACTIVE_WORDS (H_ACTIVE_WORDS),
        .H_FRONT_WORDS  (H_FRONT_WORDS),
        .VSA_LINES      (VSA_LINES),
        .VBP_LINES      (VBP_LINES),
        .V_ACTIVE_LINES (V_ACTIVE_LINES),
        .VFP_LINES      (VFP_LINES),
        .WC_WIDTH       (16)
    ) DUT (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .streaming_enable        (streaming_enable),
        .pix_fifo_data           (pix_fifo_data),
        .pix_fifo_empty          (pix_fifo_empty),
        .pix_fifo_read           (pix_fifo_read),
        .data_rqst               (data_rqst),
        .write_data              (write_data),
        .write_strb              (write_strb),
        .write_rqst              (write_rqst),
        .last_word               (last_word)
    );

    bind dsi_video_assembler dsi_assembler_checker u_checker
    (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .data_rqst               (data_rqst),
        .write_rqst              (write_rqst),
        .write_data              (write_data),
        .write_strb              (write_strb),
        .last_word               (last_word),
        .pix_fifo_read           (pix_fifo_read),
        .pix_fifo_empty          (pix_fifo_empty)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
            abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want));
    endtask

    task automatic check_idle_outputs();
        check_value("write_rqst", write_rqst, 0);
        check_value("last_word", last_word, 0);
        check_value("pix_fifo_read", pix_fifo_read, 0);
    endtask

    // hamming parity bits of the dsi packet header
    function automatic logic [7:0] ecc_of(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        return {2'b00, p};
    endfunction

    function automatic logic [15:0] crc_word(input logic [15:0] crc_in, input logic [31:0] w);
        logic [15:0] c;
        logic [7:0]  b;
        c = crc_in;
        for (int n = 0; n < 4; n++)
        begin
            b = w[8*n +: 8]; // byte 0 first, each byte lsb first
            for (int k = 0; k < 8; k++)
                c = (c[0] ^ b[k]) ? ((c >> 1) ^ 16'h8408) : (c >> 1);
        end
        return c;
    endfunction

    function automatic void push_word(input logic [31:0] d, input logic [3:0] s, input logic l);
        exp_data.push_back(d);
        exp_strb.push_back(s);
        exp_last.push_back(l);
    endfunction

    function automatic logic [31:0] header_word(input logic [7:0] id, input int words);
        logic [23:0] hdr;
        hdr = {16'(words * 4), id}; // word count in bytes, low byte in byte 1
        return {ecc_of(hdr), hdr};
    endfunction

    function automatic void add_long(input logic [7:0] id, input int words, input logic pixel);
        logic [15:0] crc;
        logic [31:0] w;
        crc = 16'hFFFF;
        push_word(header_word(id, words), 4'b1111, 1'b0);
        for (int i = 0; i < words; i++)
        begin
            w = pixel ? (PIX_BASE + ref_pix) : 32'h5555_5555;
            if (pixel)
                ref_pix = ref_pix + 1;
            crc = crc_word(crc, w);
            push_word(w, 4'b1111, 1'b0);
        end
        push_word({16'h0000, crc}, 4'b0011, 1'b1);
    endfunction

    // expected word stream of one whole frame
    function automatic void build_frame();
        push_word(header_word(8'h01, 0), 4'b1111, 1'b1);
        for (int l = 0; l < VSA_LINES + VBP_LINES; l++)
        begin
            push_word(header_word(8'h21, 0), 4'b1111, 1'b1);
            add_long(8'h19, LINE_WORDS, 1'b0);
        end
        for (int l = 0; l < V_ACTIVE_LINES; l++)
        begin
            push_word(header_word(8'h21, 0), 4'b1111, 1'b1);
            add_long(8'h19, H_BACK_WORDS, 1'b0);
            add_long(8'h3E, H_ACTIVE_WORDS, 1'b1);
            add_long(8'h19, H_FRONT_WORDS, 1'b0);
        end
        for (int l = 0; l < VFP_LINES; l++)
        begin
            push_word(header_word(8'h21, 0), 4'b1111, 1'b1);
            add_long(8'h19, LINE_WORDS, 1'b0);
        end
    endfunction

    // pixel fifo model and lanes controller back-pressure
    always @(posedge clk_sys)
    begin
        #1;
        if (pix_take)
            pix_next = pix_next + 1;
        pix_fifo_data  = PIX_BASE + pix_next;
        pix_fifo_empty = underrun_en ? (($urandom % 4) == 0) : 1'b0;
        data_rqst      = stall_en ? (($urandom % 3) != 0) : 1'b1;
    end

    // compares every consumed word in mid-cycle, where all signals are settled
    always @(negedge clk_sys)
    begin
        pix_take = pix_fifo_read;
        if (!reset_stop_read_data_hs)
        begin
            if (DUT.u_checker.fail_count != 0)
                abort_run("a protocol assertion on the DUT ports failed");
            if (pix_fifo_read && pix_fifo_empty)
                abort_run("pix_fifo_read pulsed while the pixel FIFO was empty");
            if (write_rqst && data_rqst)
            begin
                if (exp_data.size() == 0)
                    abort_run("the DUT wrote a word when no packet was expected");
                check_value("write_data", write_data, exp_data.pop_front());
                check_value("write_strb", write_strb, exp_strb.pop_front());
                check_value("last_word", last_word, exp_last.pop_front());
            end
        end
    end

    always @(posedge clk_sys)
    begin
        if (watch_on)
        begin
            watch_cycles = watch_cycles + 1;
            if (watch_cycles > WATCH_LIMIT)
                abort_run("timeout: the DUT did not deliver the expected frames in time");
        end
    end

    // streams whole frames and lowers streaming_enable once drop_left words remain
    task automatic run_stream(input int frames, input logic stall, input logic underrun,
                              input int drop_left);
        @(negedge clk_sys);
        ref_pix = 0;
        pix_next = 0;
        for (int f = 0; f < frames; f++)
            build_frame();
        stall_en = stall;
        underrun_en = underrun;
        watch_cycles = 0;
        watch_on = 1'b1;
        @(posedge clk_sys);
        #1 streaming_enable = 1'b1;
        do
            @(posedge clk_sys);
        while (exp_data.size() > drop_left);
        #1 streaming_enable = 1'b0;
        while (exp_data.size() != 0)
            @(posedge clk_sys);
        watch_on = 1'b0;
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk_sys);
            check_idle_outputs(); // the finished frame is not followed by another vss
        end
    endtask

    initial
    begin
        void'($urandom(RAND_SEED));
        reset_stop_read_data_hs = 1'b1;
        streaming_enable = 1'b0;
        data_rqst = 1'b1;
        pix_fifo_empty = 1'b0;
        pix_fifo_data = PIX_BASE;
        pix_next = 0;
        stall_en = 1'b0;
        underrun_en = 1'b0;
        watch_on = 1'b0;
        watch_cycles = 0;
        @(posedge clk_sys); // registers take their reset values at this first edge
        repeat (RESET_CYCLES - 1)
        begin
            @(negedge clk_sys);
            check_idle_outputs();
        end
        @(posedge clk_sys);
        #1 reset_stop_read_data_hs = 1'b0;
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk_sys);
            check_idle_outputs();
        end
        run_stream(2, 1'b0, 1'b0, FRAME_WORDS / 2);  // no stalls at all
        run_stream(2, 1'b1, 1'b0, FRAME_WORDS / 2);  // same stream under back-pressure
        run_stream(2, 1'b0, 1'b1, FRAME_WORDS / 2);  // pixel fifo underruns
        run_stream(2, 1'b1, 1'b1, FRAME_WORDS / 2);
        run_stream(1, 1'b1, 1'b1, FRAME_WORDS - 3);  // enable drops early in the frame
        if (DUT.u_checker.fail_count == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
            abort_run("protocol assertions failed during the run");
    end

endmodule

// File: dsi_video_assembler.f
hdl/dsi_pkg.sv
hdl/dsi_ecc_calc.sv
hdl/dsi_crc16.sv
hdl/dsi_line_timer.sv
hdl/dsi_frame_fsm.sv
hdl/dsi_packet_serializer.sv
hdl/dsi_video_assembler.sv
test/dsi_assembler_checker.sv
test/tb_dsi_video_assembler.sv
